//--- list.f
src/soc_pkg.sv
src/obi_bus_if.sv
src/bus_demux.sv
src/sram_bank.sv
src/soc_ctrl_regs.sv
src/gpio_regs.sv
src/soc_domain.sv
sim/soc_domain_assert.sv
sim/tb_soc_domain.sv

//--- Makefile
# Verilator build and run for the SoC domain testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_domain
SEED      ?= 78736
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP SEED BUILD_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | \
		grep -q "^Finished with no errors$$"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_soc_domain.sv
// Testbench driving the SoC domain host bus and checking responses against a model
`timescale 1ns/10ps

module tb_soc_domain;

  localparam int unsigned GpioCount  = 16;
  localparam int unsigned SramWords  = 16;
  localparam int unsigned RandWrites = 24;

  logic                 clk;
  logic                 rst_n;
  logic                 fetch_en;
  logic                 bus_req;
  logic                 bus_we;
  soc_pkg::addr_t       bus_addr;
  soc_pkg::be_t         bus_be;
  soc_pkg::data_t       bus_wdata;
  logic [GpioCount-1:0] gpio_in;
  logic                 bus_gnt;
  logic                 bus_rvalid;
  logic                 bus_err;
  soc_pkg::data_t       bus_rdata;
  logic [GpioCount-1:0] gpio_out;
  logic [GpioCount-1:0] gpio_out_en;
  logic [GpioCount-1:0] gpio_in_sync;
  logic                 gpio_irq;
  soc_pkg::addr_t       boot_addr;
  logic                 fetch_enable;

  // Model state
  soc_pkg::data_t       shadow_mem [soc_pkg::SramNumWords];
  soc_pkg::addr_t       sh_boot;
  logic                 sh_fetch;
  logic [GpioCount-1:0] sh_dir;
  logic [GpioCount-1:0] sh_out;
  logic [GpioCount-1:0] sh_irq_en;
  logic [GpioCount-1:0] sh_irq_status;
  logic [GpioCount-1:0] sh_gpio_in;
  soc_pkg::data_t       exp_data_q [$];
  logic                 exp_err_q [$];

  int             seed;
  int             steps        = 0;
  int             cycles       = 0;
  int             out_errors   = 0;
  int             rsp_errors   = 0;
  int             proto_errors = 0;
  logic           accepted_q   = 1'b0;
  soc_pkg::data_t cmp_data;
  logic           cmp_err;

  soc_domain #(
    .GpioCount ( GpioCount )
  ) UUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .fetch_en_i     ( fetch_en     ),
    .bus_req_i      ( bus_req      ),
    .bus_we_i       ( bus_we       ),
    .bus_addr_i     ( bus_addr     ),
    .bus_be_i       ( bus_be       ),
    .bus_wdata_i    ( bus_wdata    ),
    .bus_gnt_o      ( bus_gnt      ),
    .bus_rvalid_o   ( bus_rvalid   ),
    .bus_err_o      ( bus_err      ),
    .bus_rdata_o    ( bus_rdata    ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_out_en  ),
    .gpio_in_sync_o ( gpio_in_sync ),
    .gpio_irq_o     ( gpio_irq     ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic hits(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                soc_pkg::addr_t size);
    return (addr >= base) && (addr <= base + (size - 1));
  endfunction

  function automatic soc_pkg::sram_idx_t word_of(soc_pkg::addr_t addr);
    return soc_pkg::sram_idx_t'((addr - soc_pkg::SramBaseAddr) >> 2);
  endfunction

  function automatic soc_pkg::addr_t ctrl_reg(logic [soc_pkg::RegOfsWidth-1:0] ofs);
    return soc_pkg::SocCtrlBaseAddr + soc_pkg::addr_t'(ofs);
  endfunction

  function automatic soc_pkg::addr_t gpio_reg(logic [soc_pkg::RegOfsWidth-1:0] ofs);
    return soc_pkg::GpioBaseAddr + soc_pkg::addr_t'(ofs);
  endfunction

  // Expected response of one transfer with the err flag in the top bit
  function automatic logic [32:0] exp_read(logic we, soc_pkg::addr_t addr);
    logic [soc_pkg::RegOfsWidth-1:0] ofs;
    soc_pkg::data_t                  data;
    logic                            err;
    ofs  = addr[soc_pkg::RegOfsWidth-1:0];
    data = '0;
    err  = 1'b0;
    if (hits(addr, soc_pkg::SramBaseAddr, soc_pkg::SramSize)) begin
      data = shadow_mem[word_of(addr)];
    end else if (hits(addr, soc_pkg::SocCtrlBaseAddr, soc_pkg::PeriphSize)) begin
      case (ofs)
        soc_pkg::SocCtrlBootAddrOfs: data = sh_boot;
        soc_pkg::SocCtrlFetchEnOfs:  data = soc_pkg::data_t'(sh_fetch);
        default:                     data = '0;
      endcase
    end else if (hits(addr, soc_pkg::GpioBaseAddr, soc_pkg::PeriphSize)) begin
      case (ofs)
        soc_pkg::GpioDirOfs:       data = soc_pkg::data_t'(sh_dir);
        soc_pkg::GpioOutOfs:       data = soc_pkg::data_t'(sh_out);
        soc_pkg::GpioInOfs:        data = soc_pkg::data_t'(sh_gpio_in);
        soc_pkg::GpioIrqEnOfs:     data = soc_pkg::data_t'(sh_irq_en);
        soc_pkg::GpioIrqStatusOfs: data = soc_pkg::data_t'(sh_irq_status);
        default:                   data = '0;
      endcase
    end else begin
      err  = 1'b1;
      data = soc_pkg::ErrRspData;
    end
    if (we) begin
      data = '0;
    end
    return {err, data};
  endfunction

  function automatic void update_shadow(soc_pkg::addr_t addr, soc_pkg::be_t be,
                                        soc_pkg::data_t wdata);
    logic [soc_pkg::RegOfsWidth-1:0] ofs;
    ofs = addr[soc_pkg::RegOfsWidth-1:0];
    if (hits(addr, soc_pkg::SramBaseAddr, soc_pkg::SramSize)) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          shadow_mem[word_of(addr)][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end else if (hits(addr, soc_pkg::SocCtrlBaseAddr, soc_pkg::PeriphSize)) begin
      case (ofs)
        soc_pkg::SocCtrlBootAddrOfs: sh_boot = wdata;
        soc_pkg::SocCtrlFetchEnOfs:  sh_fetch = wdata[0];
        default: ;
      endcase
    end else if (hits(addr, soc_pkg::GpioBaseAddr, soc_pkg::PeriphSize)) begin
      case (ofs)
        soc_pkg::GpioDirOfs:       sh_dir = wdata[GpioCount-1:0];
        soc_pkg::GpioOutOfs:       sh_out = wdata[GpioCount-1:0];
        soc_pkg::GpioIrqEnOfs:     sh_irq_en = wdata[GpioCount-1:0];
        soc_pkg::GpioIrqStatusOfs: sh_irq_status = sh_irq_status & ~wdata[GpioCount-1:0];
        default: ;
      endcase
    end
  endfunction

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  task automatic issue(input logic we, input soc_pkg::addr_t addr, input soc_pkg::be_t be,
                       input soc_pkg::data_t wdata);
    logic [32:0] rsp;
    @(posedge clk);
    bus_req   <= 1'b1;
    bus_we    <= we;
    bus_addr  <= addr;
    bus_be    <= be;
    bus_wdata <= wdata;
    rsp = exp_read(we, addr);
    exp_err_q.push_back(rsp[32]);
    exp_data_q.push_back(rsp[31:0]);
    if (we) begin
      update_shadow(addr, be, wdata);
    end
    steps++;
  endtask

  task automatic write_word(input soc_pkg::addr_t addr, input soc_pkg::data_t data);
    issue(1'b1, addr, 4'hF, data);
  endtask

  task automatic read_word(input soc_pkg::addr_t addr);
    issue(1'b0, addr, 4'hF, '0);
  endtask

  task automatic idle(input int n);
    @(posedge clk);
    bus_req <= 1'b0;
    bus_we  <= 1'b0;
    repeat (n - 1) @(posedge clk);
    steps += n;
  endtask

  // New pin value followed by room for the synchronizer
  task automatic set_gpio(input logic [GpioCount-1:0] value);
    @(posedge clk);
    bus_req <= 1'b0;
    gpio_in <= value;
    sh_irq_status = sh_irq_status | (value & ~sh_gpio_in & sh_irq_en);
    steps++;
    idle(4);
    sh_gpio_in = value;
  endtask

  function automatic void check_val(string what, soc_pkg::data_t got, soc_pkg::data_t exp);
    assert (got == exp) else begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      out_errors++;
    end
  endfunction

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    int unsigned idx;
    seed      = 78736;
    rst_n     = 1'b0;
    fetch_en  = 1'b0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_be    = '0;
    bus_wdata = '0;
    gpio_in   = '0;
    sh_boot       = soc_pkg::SramBaseAddr;
    sh_fetch      = 1'b0;
    sh_dir        = '0;
    sh_out        = '0;
    sh_irq_en     = '0;
    sh_irq_status = '0;
    sh_gpio_in    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    idle(2);

    // Reset values
    @(negedge clk);
    check_val("boot_addr_o", boot_addr, soc_pkg::SramBaseAddr);
    check_val("fetch_enable_o", soc_pkg::data_t'(fetch_enable), '0);
    check_val("bus_rvalid_o", soc_pkg::data_t'(bus_rvalid), '0);
    check_val("bus_err_o", soc_pkg::data_t'(bus_err), '0);
    check_val("gpio_irq_o", soc_pkg::data_t'(gpio_irq), '0);
    check_val("gpio_out_en_o", soc_pkg::data_t'(gpio_out_en), '0);
    check_val("gpio_o", soc_pkg::data_t'(gpio_out), '0);

    // SRAM fill and random byte merges followed by read back
    for (int i = 0; i < SramWords; i++) begin
      write_word(soc_pkg::SramBaseAddr + 4 * i, $random(seed));
    end
    for (int i = 0; i < RandWrites; i++) begin
      idx = $unsigned($random(seed)) % SramWords;
      issue(1'b1, soc_pkg::SramBaseAddr + 4 * idx, soc_pkg::be_t'($random(seed)),
            $random(seed));
    end
    for (int i = 0; i < SramWords; i++) begin
      read_word(soc_pkg::SramBaseAddr + 4 * i);
    end
    idle(3);

    // SoC control
    read_word(ctrl_reg(soc_pkg::SocCtrlBootAddrOfs));
    read_word(ctrl_reg(soc_pkg::SocCtrlFetchEnOfs));
    write_word(ctrl_reg(soc_pkg::SocCtrlBootAddrOfs), 32'h1000_0080);
    write_word(ctrl_reg(soc_pkg::SocCtrlFetchEnOfs), 32'h0000_0001);
    idle(1);
    @(negedge clk);
    check_val("boot_addr_o", boot_addr, sh_boot);
    check_val("fetch_enable_o", soc_pkg::data_t'(fetch_enable), soc_pkg::data_t'(sh_fetch));
    read_word(ctrl_reg(soc_pkg::SocCtrlBootAddrOfs));
    read_word(ctrl_reg(soc_pkg::SocCtrlFetchEnOfs));
    write_word(ctrl_reg(soc_pkg::SocCtrlFetchEnOfs), 32'h0000_0000);
    idle(1);
    fetch_en <= 1'b1;
    @(negedge clk);
    check_val("fetch_enable_o from pin", soc_pkg::data_t'(fetch_enable), 32'h1);
    @(posedge clk);
    fetch_en <= 1'b0;
    @(negedge clk);
    check_val("fetch_enable_o pin low", soc_pkg::data_t'(fetch_enable), '0);

    // GPIO outputs
    write_word(gpio_reg(soc_pkg::GpioDirOfs), 32'h0000_A5F0);
    write_word(gpio_reg(soc_pkg::GpioOutOfs), 32'h0000_5A0F);
    idle(1);
    @(negedge clk);
    check_val("gpio_out_en_o", soc_pkg::data_t'(gpio_out_en), soc_pkg::data_t'(sh_dir));
    check_val("gpio_o", soc_pkg::data_t'(gpio_out), soc_pkg::data_t'(sh_out));
    read_word(gpio_reg(soc_pkg::GpioDirOfs));
    read_word(gpio_reg(soc_pkg::GpioOutOfs));

    // GPIO inputs and interrupt with only bit 0 enabled
    write_word(gpio_reg(soc_pkg::GpioIrqEnOfs), 32'h0000_0001);
    set_gpio(16'h0002);
    @(negedge clk);
    check_val("gpio_in_sync_o", soc_pkg::data_t'(gpio_in_sync), soc_pkg::data_t'(sh_gpio_in));
    check_val("gpio_irq_o", soc_pkg::data_t'(gpio_irq), '0);
    read_word(gpio_reg(soc_pkg::GpioInOfs));
    read_word(gpio_reg(soc_pkg::GpioIrqEnOfs));
    read_word(gpio_reg(soc_pkg::GpioIrqStatusOfs));
    set_gpio(16'h0003);
    @(negedge clk);
    check_val("gpio_in_sync_o", soc_pkg::data_t'(gpio_in_sync), soc_pkg::data_t'(sh_gpio_in));
    check_val("gpio_irq_o", soc_pkg::data_t'(gpio_irq), 32'h1);
    read_word(gpio_reg(soc_pkg::GpioInOfs));
    read_word(gpio_reg(soc_pkg::GpioIrqStatusOfs));
    write_word(gpio_reg(soc_pkg::GpioIrqStatusOfs), 32'h0000_0001);
    idle(1);
    @(negedge clk);
    check_val("gpio_irq_o after clear", soc_pkg::data_t'(gpio_irq), '0);
    read_word(gpio_reg(soc_pkg::GpioIrqStatusOfs));

    // Error path and unused offsets
    read_word(32'h2000_0000);
    write_word(soc_pkg::SramBaseAddr + soc_pkg::SramSize, 32'hDEAD_BEEF);
    read_word(soc_pkg::SramBaseAddr);
    read_word(ctrl_reg(12'h008));
    read_word(gpio_reg(12'h020));
    write_word(ctrl_reg(12'h008), 32'hFFFF_FFFF);
    read_word(ctrl_reg(soc_pkg::SocCtrlBootAddrOfs));
    idle(4);

    assert (exp_data_q.size() == 0) else begin
      $display("%0d responses never arrived", exp_data_q.size());
      out_errors++;
    end
    $display("Errors: %0d output, %0d response, %0d protocol",
             out_errors, rsp_errors, proto_errors);
    if (out_errors + rsp_errors + proto_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // Response checker at the falling edge
  // ----------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      assert (bus_rvalid == accepted_q) else begin
        $display("Response timing wrong at %0t: rvalid is %b one cycle after request %b",
                 $time, bus_rvalid, accepted_q);
        proto_errors++;
      end
      assert (!bus_rvalid || exp_data_q.size() > 0) else begin
        $display("Extra response at %0t with no request outstanding", $time);
        proto_errors++;
      end
      if (bus_rvalid && exp_data_q.size() > 0) begin
        cmp_data = exp_data_q.pop_front();
        cmp_err  = exp_err_q.pop_front();
        assert ((bus_rdata == cmp_data) && (bus_err == cmp_err)) else begin
          $display("FAIL %0t: response %h err %b, expected %h err %b",
                   $time, bus_rdata, bus_err, cmp_data, cmp_err);
          rsp_errors++;
        end
      end
    end
    accepted_q = rst_n && bus_req && bus_gnt;
  end

  // Run limit follows the number of issued transfers and waits
  always @(posedge clk) begin
    cycles++;
    if (cycles > 2 * steps + 200) begin
      $display("Timeout after %0d cycles, the test sequence stalled", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

//--- sim/soc_domain_assert.sv
// Bus protocol checks on the address decoder, attached to bus_demux by bind
`timescale 1ns/10ps

module soc_domain_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic accept_i,
  input logic rvalid_i,
  input logic sram_req_i,
  input logic ctrl_req_i,
  input logic gpio_req_i
);

  logic seen_accept_q;

  // Set by the first accepted request after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_accept_q <= 1'b0;
    end else if (accept_i) begin
      seen_accept_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------
  a_rsp_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) accept_i |=> rvalid_i
  ) else $error("rvalid missing one cycle after an accepted request");

  a_rsp_has_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_i |-> $past(accept_i)
  ) else $error("rvalid without an accepted request in the previous cycle");

  a_one_sbr_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0({sram_req_i, ctrl_req_i, gpio_req_i})
  ) else $error("more than one subordinate request high");

  // No response before the first request after reset
  a_quiet_after_reset: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !seen_accept_q |-> !rvalid_i
  ) else $error("rvalid high before any request was accepted");

endmodule

bind bus_demux soc_domain_assert i_soc_domain_assert (
  .clk_i      ( clk_i       ),
  .rst_n_i    ( rst_n_i     ),
  .accept_i   ( accept      ),
  .rvalid_i   ( host.rvalid ),
  .sram_req_i ( sram.req    ),
  .ctrl_req_i ( ctrl.req    ),
  .gpio_req_i ( gpio.req    )
);

//--- src/soc_domain.sv
// SoC domain top level joining the host bus, SRAM, SoC control and GPIO
`timescale 1ns/10ps

module soc_domain #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 fetch_en_i,

  // Host bus
  input  logic                 bus_req_i,
  input  logic                 bus_we_i,
  input  soc_pkg::addr_t       bus_addr_i,
  input  soc_pkg::be_t         bus_be_i,
  input  soc_pkg::data_t       bus_wdata_i,
  output logic                 bus_gnt_o,
  output logic                 bus_rvalid_o,
  output logic                 bus_err_o,
  output soc_pkg::data_t       bus_rdata_o,

  // GPIO pins
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 gpio_irq_o,

  // Core boot control
  output soc_pkg::addr_t       boot_addr_o,
  output logic                 fetch_enable_o
);

  // ----------------------------------------------------------
  // Bus links
  // ----------------------------------------------------------
  obi_bus_if host_bus ();
  obi_bus_if sram_bus ();
  obi_bus_if ctrl_bus ();
  obi_bus_if gpio_bus ();

  // Host link driven straight from the pins
  assign host_bus.req   = bus_req_i;
  assign host_bus.addr  = bus_addr_i;
  assign host_bus.we    = bus_we_i;
  assign host_bus.be    = bus_be_i;
  assign host_bus.wdata = bus_wdata_i;

  assign bus_gnt_o    = host_bus.gnt;
  assign bus_rvalid_o = host_bus.rvalid;
  assign bus_rdata_o  = host_bus.rdata;
  assign bus_err_o    = host_bus.err;

  // ----------------------------------------------------------
  // Decoder and subordinates
  // ----------------------------------------------------------
  bus_demux i_bus_demux (
    .clk_i,
    .rst_n_i,
    .host ( host_bus ),
    .sram ( sram_bus ),
    .ctrl ( ctrl_bus ),
    .gpio ( gpio_bus )
  );

  sram_bank i_sram_bank (
    .clk_i,
    .rst_n_i,
    .bus ( sram_bus )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .fetch_en_i,
    .bus            ( ctrl_bus       ),
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) i_gpio (
    .clk_i,
    .rst_n_i,
    .bus            ( gpio_bus   ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq_o )
  );

endmodule

//--- src/gpio_regs.sv
// GPIO block with direction and output registers, input sync and edge interrupt
`timescale 1ns/10ps

module gpio_regs #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  obi_bus_if.sbr               bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);

  logic [soc_pkg::RegOfsWidth-1:0] ofs;
  logic                            wr_en;
  logic [GpioCount-1:0]            wr_bits;
  logic [GpioCount-1:0]            dir_q;
  logic [GpioCount-1:0]            out_q;
  logic [GpioCount-1:0]            irq_en_q;
  logic [GpioCount-1:0]            irq_status_q;
  logic [GpioCount-1:0]            sync1_q;
  logic [GpioCount-1:0]            sync2_q;
  logic [GpioCount-1:0]            prev_q;
  logic [GpioCount-1:0]            rise;
  logic [GpioCount-1:0]            status_clr;
  soc_pkg::data_t                  rdata_q;
  logic                            rvalid_q;

  assign ofs     = bus.addr[soc_pkg::RegOfsWidth-1:0];
  assign wr_en   = bus.req && bus.we;
  assign wr_bits = bus.wdata[GpioCount-1:0];

  // ----------------------------------------------------------
  // Input synchronizer and edge detect
  // ----------------------------------------------------------
  assign rise = sync2_q & ~prev_q;

  // Writing ones clears status bits unless a new edge arrives
  assign status_clr = (wr_en && (ofs == soc_pkg::GpioIrqStatusOfs)) ? wr_bits : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q      <= '0;
      sync2_q      <= '0;
      prev_q       <= '0;
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      sync1_q      <= gpio_i;
      sync2_q      <= sync1_q;
      prev_q       <= sync2_q;
      // Only enabled bits latch an edge
      irq_status_q <= (irq_status_q & ~status_clr) | (rise & irq_en_q);
      rvalid_q     <= bus.req;
      if (wr_en && (ofs == soc_pkg::GpioDirOfs)) begin
        dir_q <= wr_bits;
      end
      if (wr_en && (ofs == soc_pkg::GpioOutOfs)) begin
        out_q <= wr_bits;
      end
      if (wr_en && (ofs == soc_pkg::GpioIrqEnOfs)) begin
        irq_en_q <= wr_bits;
      end
    end
  end

  // ----------------------------------------------------------
  // Read-back
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        rdata_q <= '0;
      end else begin
        case (ofs)
          soc_pkg::GpioDirOfs:       rdata_q <= soc_pkg::data_t'(dir_q);
          soc_pkg::GpioOutOfs:       rdata_q <= soc_pkg::data_t'(out_q);
          soc_pkg::GpioInOfs:        rdata_q <= soc_pkg::data_t'(sync2_q);
          soc_pkg::GpioIrqEnOfs:     rdata_q <= soc_pkg::data_t'(irq_en_q);
          soc_pkg::GpioIrqStatusOfs: rdata_q <= soc_pkg::data_t'(irq_status_q);
          default:                   rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |(irq_status_q & irq_en_q);

endmodule

//--- src/soc_ctrl_regs.sv
// SoC control registers holding the boot address and the fetch enable
`timescale 1ns/10ps

module soc_ctrl_regs (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           fetch_en_i,
  obi_bus_if.sbr         bus,
  output soc_pkg::addr_t boot_addr_o,
  output logic           fetch_enable_o
);

  logic [soc_pkg::RegOfsWidth-1:0] ofs;
  logic                            wr_en;
  soc_pkg::addr_t                  boot_addr_q;
  logic                            fetch_en_q;
  soc_pkg::data_t                  rdata_q;
  logic                            rvalid_q;

  assign ofs   = bus.addr[soc_pkg::RegOfsWidth-1:0];
  assign wr_en = bus.req && bus.we;

  // ----------------------------------------------------------
  // Registers, whole-word writes
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= soc_pkg::SramBaseAddr;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (wr_en && (ofs == soc_pkg::SocCtrlBootAddrOfs)) begin
        boot_addr_q <= bus.wdata;
      end
      if (wr_en && (ofs == soc_pkg::SocCtrlFetchEnOfs)) begin
        fetch_en_q <= bus.wdata[0];
      end
    end
  end

  // Read-back, unused offsets read zero
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        rdata_q <= '0;
      end else if (ofs == soc_pkg::SocCtrlBootAddrOfs) begin
        rdata_q <= boot_addr_q;
      end else if (ofs == soc_pkg::SocCtrlFetchEnOfs) begin
        rdata_q <= soc_pkg::data_t'(fetch_en_q);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  // Pin can also start the core
  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

//--- src/sram_bank.sv
// Single-port word SRAM bank with byte enables on a bus subordinate port
`timescale 1ns/10ps

module sram_bank (
  input logic    clk_i,
  input logic    rst_n_i,
  obi_bus_if.sbr bus
);

  soc_pkg::data_t    mem [soc_pkg::SramNumWords];
  soc_pkg::sram_idx_t idx;
  soc_pkg::data_t    rdata_q;
  logic              rvalid_q;

  // Word index sits just above the byte offset
  assign idx = bus.addr[$bits(soc_pkg::sram_idx_t)+1:2];

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int b = 0; b < $bits(soc_pkg::be_t); b++) begin
        if (bus.be[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      rdata_q <= '0;
    end else if (bus.req) begin
      rdata_q <= mem[idx];
    end
  end

  // One-cycle response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  // Always ready, never faults
  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

//--- src/bus_demux.sv
// Address decoder routing host requests to SRAM, SoC control, GPIO or error responder
`timescale 1ns/10ps

module bus_demux (
  input logic    clk_i,
  input logic    rst_n_i,
  obi_bus_if.sbr host,
  obi_bus_if.mgr sram,
  obi_bus_if.mgr ctrl,
  obi_bus_if.mgr gpio
);

  soc_pkg::sel_t  sel_d;
  soc_pkg::sel_t  sel_q;
  logic           accept;
  logic           err_rvalid_q;
  soc_pkg::data_t err_rdata_q;

  function automatic logic in_window(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                     soc_pkg::addr_t size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  always_comb begin
    if (in_window(host.addr, soc_pkg::SramBaseAddr, soc_pkg::SramSize)) begin
      sel_d = soc_pkg::SelSram;
    end else if (in_window(host.addr, soc_pkg::SocCtrlBaseAddr, soc_pkg::PeriphSize)) begin
      sel_d = soc_pkg::SelSocCtrl;
    end else if (in_window(host.addr, soc_pkg::GpioBaseAddr, soc_pkg::PeriphSize)) begin
      sel_d = soc_pkg::SelGpio;
    end else begin
      sel_d = soc_pkg::SelError;
    end
  end

  // Only the selected link sees req, payload fans out to all
  assign sram.req   = host.req && (sel_d == soc_pkg::SelSram);
  assign sram.addr  = host.addr;
  assign sram.we    = host.we;
  assign sram.be    = host.be;
  assign sram.wdata = host.wdata;

  assign ctrl.req   = host.req && (sel_d == soc_pkg::SelSocCtrl);
  assign ctrl.addr  = host.addr;
  assign ctrl.we    = host.we;
  assign ctrl.be    = host.be;
  assign ctrl.wdata = host.wdata;

  assign gpio.req   = host.req && (sel_d == soc_pkg::SelGpio);
  assign gpio.addr  = host.addr;
  assign gpio.we    = host.we;
  assign gpio.be    = host.be;
  assign gpio.wdata = host.wdata;

  always_comb begin
    case (sel_d)
      soc_pkg::SelSram:    host.gnt = sram.gnt;
      soc_pkg::SelSocCtrl: host.gnt = ctrl.gnt;
      soc_pkg::SelGpio:    host.gnt = gpio.gnt;
      default:             host.gnt = 1'b1;
    endcase
  end

  assign accept = host.req && host.gnt;

  // ----------------------------------------------------------
  // Select tracking and error responder
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q        <= soc_pkg::SelError;
      err_rvalid_q <= 1'b0;
    end else begin
      if (accept) begin
        sel_q <= sel_d;
      end
      err_rvalid_q <= accept && (sel_d == soc_pkg::SelError);
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (accept && (sel_d == soc_pkg::SelError)) begin
      err_rdata_q <= host.we ? '0 : soc_pkg::ErrRspData;
    end
  end

  // Response steered by the select captured at acceptance
  always_comb begin
    case (sel_q)
      soc_pkg::SelSram: begin
        host.rvalid = sram.rvalid;
        host.rdata  = sram.rdata;
        host.err    = sram.err;
      end
      soc_pkg::SelSocCtrl: begin
        host.rvalid = ctrl.rvalid;
        host.rdata  = ctrl.rdata;
        host.err    = ctrl.err;
      end
      soc_pkg::SelGpio: begin
        host.rvalid = gpio.rvalid;
        host.rdata  = gpio.rdata;
        host.err    = gpio.err;
      end
      default: begin
        host.rvalid = err_rvalid_q;
        host.rdata  = err_rdata_q;
        host.err    = err_rvalid_q;
      end
    endcase
  end

endmodule

//--- src/obi_bus_if.sv
// Single bus link with request channel from manager and response channel back
`timescale 1ns/10ps

interface obi_bus_if;

  // Request channel
  logic           req;
  soc_pkg::addr_t addr;
  logic           we;
  soc_pkg::be_t   be;
  soc_pkg::data_t wdata;

  // Response channel, rvalid one cycle after acceptance
  logic           gnt;
  logic           rvalid;
  soc_pkg::data_t rdata;
  logic           err;

  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sbr (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

//--- src/soc_pkg.sv
// SoC domain bus types, address map and register offsets shared by all blocks
package soc_pkg;

  // ----------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Word index inside the SRAM bank
  typedef logic [7:0]  sram_idx_t;

  // Subordinate select driven by the address decoder
  typedef logic [1:0]  sel_t;

  localparam sel_t SelSram    = 2'd0;
  localparam sel_t SelSocCtrl = 2'd1;
  localparam sel_t SelGpio    = 2'd2;
  localparam sel_t SelError   = 2'd3;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam addr_t       SramBaseAddr = 32'h1000_0000;
  localparam addr_t       SramSize     = 32'h0000_0400;
  localparam int unsigned SramNumWords = 256;

  localparam addr_t SocCtrlBaseAddr = 32'h0300_0000;
  localparam addr_t GpioBaseAddr    = 32'h0300_5000;

  // Size of every peripheral register window
  localparam addr_t PeriphSize = 32'h0000_1000;

  // Read data of the error responder
  localparam data_t ErrRspData = 32'hBADC_AB1E;

  // ----------------------------------------------------------
  // Register offsets
  // ----------------------------------------------------------
  localparam int unsigned RegOfsWidth = 12;

  // SoC control block
  localparam logic [RegOfsWidth-1:0] SocCtrlBootAddrOfs = 12'h000;
  localparam logic [RegOfsWidth-1:0] SocCtrlFetchEnOfs  = 12'h004;

  // GPIO block
  localparam logic [RegOfsWidth-1:0] GpioDirOfs       = 12'h000;
  localparam logic [RegOfsWidth-1:0] GpioOutOfs       = 12'h004;
  localparam logic [RegOfsWidth-1:0] GpioInOfs        = 12'h008;
  localparam logic [RegOfsWidth-1:0] GpioIrqEnOfs     = 12'h00C;
  localparam logic [RegOfsWidth-1:0] GpioIrqStatusOfs = 12'h010;

endpackage
